// ==== common/rapid_recovery_pkg.sv ====
package rapid_recovery_pkg;

  // Width of one architectural register and of one CSR
  localparam int unsigned DataWidth = 32;

  // Architectural register count of the integer register file
  localparam int unsigned NumRegs = 32;

  // Register file address width
  localparam int unsigned RfAddrWidth = 5;

  // Restore cycles for the register file
  // Port A covers the lower half while port B covers the upper half
  localparam int unsigned RestoreSteps = NumRegs / 2;

  // One register file write port
  typedef struct packed {
    logic                   we;
    logic [RfAddrWidth-1:0] addr;
    logic [DataWidth-1:0]   data;
  } rf_write_t;

  // Both write ports together
  // Used for commit writes from the core and for restore writes to it
  typedef struct packed {
    rf_write_t port_a;
    rf_write_t port_b;
  } regfile_write_t;

  // Machine CSRs kept in the shadow copy
  typedef struct packed {
    logic [DataWidth-1:0] mstatus;
    logic [DataWidth-1:0] mie;
    logic [DataWidth-1:0] mtvec;
    logic [DataWidth-1:0] mscratch;
    logic [DataWidth-1:0] mepc;
    logic [DataWidth-1:0] mcause;
  } csr_state_t;

  // Program counter
  typedef logic [DataWidth-1:0] pc_state_t;

  // Recovery sequencer states
  typedef enum logic [1:0] {
    IDLE,
    RESET,
    HALT,
    RESTORE
  } recovery_mode_e;

endpackage

// ==== logic/rf_backup.sv ====
module rf_backup (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  // Capture commits while high
  input  logic                                        backup_en_i,
  // Commit writes from the core
  input  rapid_recovery_pkg::regfile_write_t          core_write_i,
  // Restore control
  input  logic                                        restore_en_i,
  input  logic [rapid_recovery_pkg::RfAddrWidth-2:0] restore_addr_i,
  // Write pair back to the core
  output rapid_recovery_pkg::regfile_write_t          restore_write_o
);

  import rapid_recovery_pkg::*;

  // Shadow copy of the register file
  logic [NumRegs-1:0][DataWidth-1:0] shadow_q;

  // Restore addresses for both halves
  logic [RfAddrWidth-1:0] addr_lo;
  logic [RfAddrWidth-1:0] addr_hi;

  // Capture of committed writes
  // Port B is applied last so it wins on equal addresses
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shadow_q <= '0;
    end else if (backup_en_i) begin
      if (core_write_i.port_a.we) begin
        shadow_q[core_write_i.port_a.addr] <= core_write_i.port_a.data;
      end
      if (core_write_i.port_b.we) begin
        shadow_q[core_write_i.port_b.addr] <= core_write_i.port_b.data;
      end
    end
  end

  // Port A walks the lower half
  assign addr_lo = {1'b0, restore_addr_i};
  // Port B walks the upper half
  assign addr_hi = {1'b1, restore_addr_i};

  // Restore write pair read straight from the shadow copy
  always_comb begin
    restore_write_o.port_a.we   = restore_en_i;
    restore_write_o.port_a.addr = addr_lo;
    restore_write_o.port_a.data = shadow_q[addr_lo];
    restore_write_o.port_b.we   = restore_en_i;
    restore_write_o.port_b.addr = addr_hi;
    restore_write_o.port_b.data = shadow_q[addr_hi];
  end

endmodule

// ==== logic/state_backup.sv ====
module state_backup (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // Capture commits while high
  input  logic                           backup_en_i,
  // Committed PC and CSRs from the core
  input  rapid_recovery_pkg::pc_state_t  core_pc_i,
  input  logic                           core_pc_valid_i,
  input  rapid_recovery_pkg::csr_state_t core_csr_i,
  input  logic                           core_csr_valid_i,
  // Restore control
  input  logic                           pc_restore_en_i,
  input  logic                           csr_restore_en_i,
  // Replayed state towards the core
  output rapid_recovery_pkg::pc_state_t  recovery_pc_o,
  output logic                           recovery_pc_valid_o,
  output rapid_recovery_pkg::csr_state_t recovery_csr_o,
  output logic                           recovery_csr_valid_o
);

  import rapid_recovery_pkg::*;

  // Last committed values
  pc_state_t  pc_q;
  csr_state_t csr_q;

  // PC shadow register
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pc_q <= '0;
    end else if (backup_en_i && core_pc_valid_i) begin
      pc_q <= core_pc_i;
    end
  end

  // CSR shadow set, captured as a whole
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      csr_q <= '0;
    end else if (backup_en_i && core_csr_valid_i) begin
      csr_q <= core_csr_i;
    end
  end

  // Replay for the whole restore window
  assign recovery_pc_o       = pc_q;
  assign recovery_pc_valid_o = pc_restore_en_i;

  assign recovery_csr_o       = csr_q;
  assign recovery_csr_valid_o = csr_restore_en_i;

endmodule

// ==== recovery/rf_addr_gen.sv ====
module rf_addr_gen (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  // Restore in progress
  input  logic                                        enable_i,
  // Lower half address, upper half is derived from it
  output logic [rapid_recovery_pkg::RfAddrWidth-2:0] addr_o,
  output logic                                        done_o
);

  import rapid_recovery_pkg::*;

  localparam int unsigned CntWidth = RfAddrWidth - 1;

  logic [CntWidth-1:0] cnt_q;

  // Count while enabled, back to zero otherwise
  // Wrap after the last step leaves zero for the next restore
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (enable_i) begin
      cnt_q <= cnt_q + 1'b1;
    end else begin
      cnt_q <= '0;
    end
  end

  assign addr_o = cnt_q;

  // Final step of the walk
  assign done_o = enable_i && (cnt_q == CntWidth'(RestoreSteps - 1));

endmodule

// ==== recovery/recovery_ctrl.sv ====
module recovery_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  // Recovery request from the checker
  input  logic start_recovery_i,
  // Last register file step reached
  input  logic addr_gen_done_i,
  // Core reports it has halted
  input  logic debug_halt_i,
  // Core control
  output logic setback_o,
  output logic instr_lock_o,
  output logic debug_req_o,
  output logic debug_resume_o,
  output logic recovery_finished_o,
  // Shadow store control
  output logic backup_enable_o,
  output logic rf_restore_en_o,
  output logic pc_restore_en_o,
  output logic csr_restore_en_o
);

  import rapid_recovery_pkg::*;

  recovery_mode_e mode_d, mode_q;

  logic setback_d, setback_q;
  logic instr_lock_d, instr_lock_q;

  // Restore sequence completes in this cycle
  logic restore_last;

  assign restore_last = (mode_q == RESTORE) && addr_gen_done_i;

  // Next state
  always_comb begin
    mode_d = mode_q;
    unique case (mode_q)
      IDLE: begin
        if (start_recovery_i) begin
          mode_d = RESET;
        end
      end
      // Single cycle, setback issued on the way out
      RESET: begin
        mode_d = HALT;
      end
      // Wait as long as the core needs to halt
      HALT: begin
        if (debug_halt_i) begin
          mode_d = RESTORE;
        end
      end
      RESTORE: begin
        if (addr_gen_done_i) begin
          mode_d = IDLE;
        end
      end
      default: begin
        mode_d = IDLE;
      end
    endcase
  end

  // Setback is a one cycle pulse following RESET
  assign setback_d = (mode_q == RESET);

  // Lock set with the setback and held until restore is over
  always_comb begin
    instr_lock_d = instr_lock_q;
    if (mode_q == RESET) begin
      instr_lock_d = 1'b1;
    end else if (restore_last) begin
      instr_lock_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q       <= IDLE;
      setback_q    <= 1'b0;
      instr_lock_q <= 1'b0;
    end else begin
      mode_q       <= mode_d;
      setback_q    <= setback_d;
      instr_lock_q <= instr_lock_d;
    end
  end

  assign setback_o    = setback_q;
  assign instr_lock_o = instr_lock_q;

  // Shadow copy follows commits only while idle
  // A start request stops capture in the same cycle
  assign backup_enable_o = (mode_q == IDLE) && !start_recovery_i;

  // Debug request held until the halt acknowledge
  assign debug_req_o = (mode_q == HALT);

  // All three restore paths run together
  assign rf_restore_en_o  = (mode_q == RESTORE);
  assign pc_restore_en_o  = (mode_q == RESTORE);
  assign csr_restore_en_o = (mode_q == RESTORE);

  // Resume and finish flag share the last restore cycle
  assign debug_resume_o      = restore_last;
  assign recovery_finished_o = restore_last;

endmodule

// ==== recovery/rapid_recovery_unit.sv ====
module rapid_recovery_unit (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  // Request from the redundancy checker
  input  logic                               start_recovery_i,
  // Commit stage of the core
  input  rapid_recovery_pkg::regfile_write_t core_rf_write_i,
  input  rapid_recovery_pkg::pc_state_t      core_pc_i,
  input  logic                               core_pc_valid_i,
  input  rapid_recovery_pkg::csr_state_t     core_csr_i,
  input  logic                               core_csr_valid_i,
  // Debug handshake with the core
  input  logic                               debug_halt_i,
  output logic                               debug_req_o,
  output logic                               debug_resume_o,
  // Core control
  output logic                               setback_o,
  output logic                               instr_lock_o,
  // Restore traffic towards the core
  output rapid_recovery_pkg::regfile_write_t recovery_rf_write_o,
  output rapid_recovery_pkg::pc_state_t      recovery_pc_o,
  output logic                               recovery_pc_valid_o,
  output rapid_recovery_pkg::csr_state_t     recovery_csr_o,
  output logic                               recovery_csr_valid_o,
  output logic                               recovery_finished_o
);

  import rapid_recovery_pkg::*;

  // Controller to shadow stores
  logic backup_enable;
  logic rf_restore_en;
  logic pc_restore_en;
  logic csr_restore_en;

  // Address walk during restore
  logic [RfAddrWidth-2:0] restore_addr;
  logic                   addr_gen_done;

  recovery_ctrl i_recovery_ctrl (
    .clk_i,
    .rst_ni,
    .start_recovery_i,
    .addr_gen_done_i     (addr_gen_done),
    .debug_halt_i,
    .setback_o,
    .instr_lock_o,
    .debug_req_o,
    .debug_resume_o,
    .recovery_finished_o,
    .backup_enable_o     (backup_enable),
    .rf_restore_en_o     (rf_restore_en),
    .pc_restore_en_o     (pc_restore_en),
    .csr_restore_en_o    (csr_restore_en)
  );

  rf_addr_gen i_rf_addr_gen (
    .clk_i,
    .rst_ni,
    .enable_i (rf_restore_en),
    .addr_o   (restore_addr),
    .done_o   (addr_gen_done)
  );

  rf_backup i_rf_backup (
    .clk_i,
    .rst_ni,
    .backup_en_i     (backup_enable),
    .core_write_i    (core_rf_write_i),
    .restore_en_i    (rf_restore_en),
    .restore_addr_i  (restore_addr),
    .restore_write_o (recovery_rf_write_o)
  );

  state_backup i_state_backup (
    .clk_i,
    .rst_ni,
    .backup_en_i      (backup_enable),
    .core_pc_i,
    .core_pc_valid_i,
    .core_csr_i,
    .core_csr_valid_i,
    .pc_restore_en_i  (pc_restore_en),
    .csr_restore_en_i (csr_restore_en),
    .recovery_pc_o,
    .recovery_pc_valid_o,
    .recovery_csr_o,
    .recovery_csr_valid_o
  );

endmodule

// ==== sim/tb_rapid_recovery.sv ====
module tb_rapid_recovery;

  import rapid_recovery_pkg::*;

  localparam logic [31:0] Seed          = 32'h0121_d8c3;
  localparam int unsigned NumRounds     = 5;
  localparam int unsigned CommitCycles  = 200;
  localparam int unsigned TimeoutCycles = NumRounds * (CommitCycles + 30) * 2;

  // Control outputs compared as one word
  typedef struct packed {
    logic setback;
    logic lock;
    logic dreq;
    logic dresume;
    logic finished;
    logic rf_we_a;
    logic rf_we_b;
    logic pc_valid;
    logic csr_valid;
  } ctrl_t;

  logic           clk_i;
  logic           rst_ni;
  logic           start_recovery_i;
  regfile_write_t core_rf_write_i;
  pc_state_t      core_pc_i;
  logic           core_pc_valid_i;
  csr_state_t     core_csr_i;
  logic           core_csr_valid_i;
  logic           debug_halt_i;
  logic           debug_req_o;
  logic           debug_resume_o;
  logic           setback_o;
  logic           instr_lock_o;
  regfile_write_t recovery_rf_write_o;
  pc_state_t      recovery_pc_o;
  logic           recovery_pc_valid_o;
  csr_state_t     recovery_csr_o;
  logic           recovery_csr_valid_o;
  logic           recovery_finished_o;

  // Reference model of the shadow state and the sequencer
  logic [DataWidth-1:0] ref_regs [NumRegs];
  pc_state_t            ref_pc;
  csr_state_t           ref_csr;
  recovery_mode_e       ref_mode;
  int unsigned          ref_step;
  logic                 ref_setback;
  logic                 ref_lock;

  // Stimulus and core model state
  logic [31:0] rng_state;
  logic [31:0] start_draw;
  logic [2:0]  halt_wait;
  logic        halt_armed;
  logic        finished_seen;
  int unsigned idle_cycles;
  int unsigned cycle_count;

  rapid_recovery_unit dut_i (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .start_recovery_i     (start_recovery_i),
    .core_rf_write_i      (core_rf_write_i),
    .core_pc_i            (core_pc_i),
    .core_pc_valid_i      (core_pc_valid_i),
    .core_csr_i           (core_csr_i),
    .core_csr_valid_i     (core_csr_valid_i),
    .debug_halt_i         (debug_halt_i),
    .debug_req_o          (debug_req_o),
    .debug_resume_o       (debug_resume_o),
    .setback_o            (setback_o),
    .instr_lock_o         (instr_lock_o),
    .recovery_rf_write_o  (recovery_rf_write_o),
    .recovery_pc_o        (recovery_pc_o),
    .recovery_pc_valid_o  (recovery_pc_valid_o),
    .recovery_csr_o       (recovery_csr_o),
    .recovery_csr_valid_o (recovery_csr_valid_o),
    .recovery_finished_o  (recovery_finished_o)
  );

  always #20 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rand_word();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Expected control outputs in the current model state
  function automatic ctrl_t expected_ctrl();
    ctrl_t c;
    logic  restoring;
    restoring   = (ref_mode == RESTORE);
    c.setback   = ref_setback;
    c.lock      = ref_lock;
    c.dreq      = (ref_mode == HALT);
    // Resume and finish only on the 16th restore cycle
    c.dresume   = restoring && (ref_step == RestoreSteps - 1);
    c.finished  = c.dresume;
    c.rf_we_a   = restoring;
    c.rf_we_b   = restoring;
    c.pc_valid  = restoring;
    c.csr_valid = restoring;
    return c;
  endfunction

  // Restore pair for step k writes register k and register k+16
  function automatic regfile_write_t expected_restore(input int unsigned step);
    regfile_write_t w;
    w.port_a.we   = 1'b1;
    w.port_a.addr = RfAddrWidth'(step);
    w.port_a.data = ref_regs[step];
    w.port_b.we   = 1'b1;
    w.port_b.addr = RfAddrWidth'(step + RestoreSteps);
    w.port_b.data = ref_regs[step + RestoreSteps];
    return w;
  endfunction

  task automatic report_mismatch(input string msg);
    $display("Error at time %0t: %s", $time, msg);
    $display("TEST FAILED");
    $fatal(1, "Output mismatch");
  endtask

  task automatic check_outputs();
    ctrl_t          exp_c;
    ctrl_t          got_c;
    regfile_write_t exp_w;
    exp_c = expected_ctrl();
    got_c = {setback_o, instr_lock_o, debug_req_o, debug_resume_o, recovery_finished_o,
             recovery_rf_write_o.port_a.we, recovery_rf_write_o.port_b.we,
             recovery_pc_valid_o, recovery_csr_valid_o};
    assert (got_c == exp_c)
      else report_mismatch($sformatf("control outputs %b, expected %b", got_c, exp_c));
    if (ref_mode == RESTORE) begin
      exp_w = expected_restore(ref_step);
      assert (recovery_rf_write_o == exp_w)
        else report_mismatch($sformatf("restore step %0d wrote %h, expected %h",
                                       ref_step, recovery_rf_write_o, exp_w));
      assert (recovery_pc_o == ref_pc)
        else report_mismatch($sformatf("PC %h, expected %h", recovery_pc_o, ref_pc));
      assert (recovery_csr_o == ref_csr)
        else report_mismatch($sformatf("CSRs %h, expected %h", recovery_csr_o, ref_csr));
    end
  endtask

  // Advance the model by one clock edge from the inputs seen there
  task automatic update_model();
    logic last;
    last        = (ref_mode == RESTORE) && (ref_step == RestoreSteps - 1);
    ref_setback = (ref_mode == RESET);
    if (ref_mode == RESET) begin
      ref_lock = 1'b1;
    end else if (last) begin
      ref_lock = 1'b0;
    end
    case (ref_mode)
      IDLE: begin
        if (start_recovery_i) begin
          ref_mode = RESET;
        end else begin
          // Port B applied last so it wins on equal addresses
          if (core_rf_write_i.port_a.we) begin
            ref_regs[core_rf_write_i.port_a.addr] = core_rf_write_i.port_a.data;
          end
          if (core_rf_write_i.port_b.we) begin
            ref_regs[core_rf_write_i.port_b.addr] = core_rf_write_i.port_b.data;
          end
          if (core_pc_valid_i) begin
            ref_pc = core_pc_i;
          end
          if (core_csr_valid_i) begin
            ref_csr = core_csr_i;
          end
        end
      end
      RESET: ref_mode = HALT;
      HALT: begin
        if (debug_halt_i) begin
          ref_mode = RESTORE;
          ref_step = 0;
        end
      end
      default: begin
        if (last) begin
          ref_mode = IDLE;
        end else begin
          ref_step++;
        end
      end
    endcase
  endtask

  // Random commit traffic with occasional same-address pairs
  task automatic drive_commits(input logic start);
    logic [31:0] r;
    r = rand_word();
    core_rf_write_i.port_a.we   = r[0];
    core_rf_write_i.port_b.we   = r[1];
    core_pc_valid_i             = r[2];
    core_csr_valid_i            = r[3] & r[4];
    core_rf_write_i.port_a.addr = r[9:5];
    core_rf_write_i.port_b.addr = (r[11:10] == 2'b00) ? r[9:5] : r[16:12];
    core_rf_write_i.port_a.data = rand_word();
    core_rf_write_i.port_b.data = rand_word();
    core_pc_i                   = rand_word() & 32'hffff_fffc;
    core_csr_i.mstatus          = rand_word();
    core_csr_i.mie              = rand_word();
    core_csr_i.mtvec            = rand_word();
    core_csr_i.mscratch         = rand_word();
    core_csr_i.mepc             = rand_word();
    core_csr_i.mcause           = rand_word();
    start_recovery_i            = start;
  endtask

  // Core answers a debug request after 0 to 7 cycles
  task automatic answer_debug();
    if (debug_req_o) begin
      if (!halt_armed) begin
        halt_wait  = rand_word() % 8;
        halt_armed = 1'b1;
      end
      if (halt_wait == 0) begin
        debug_halt_i = 1'b1;
      end else begin
        halt_wait--;
      end
    end else begin
      debug_halt_i = 1'b0;
      halt_armed   = 1'b0;
    end
  endtask

  initial begin
    ref_pc      = '0;
    ref_csr     = '0;
    ref_mode    = IDLE;
    ref_step    = 0;
    ref_setback = 1'b0;
    ref_lock    = 1'b0;
    for (int i = 0; i < NumRegs; i++) begin
      ref_regs[i] = '0;
    end
  end

  // Compare first, then move the model past this edge
  always @(posedge clk_i) begin
    if (rst_ni) begin
      check_outputs();
      update_model();
    end
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count >= TimeoutCycles) begin
      $display("Timeout: recovery rounds did not finish within %0d cycles", TimeoutCycles);
      $display("TEST FAILED");
      $fatal(1, "Simulation timed out");
    end
  end

  initial begin
    clk_i            = 1'b0;
    rst_ni           = 1'b0;
    start_recovery_i = 1'b0;
    core_rf_write_i  = '0;
    core_pc_i        = '0;
    core_pc_valid_i  = 1'b0;
    core_csr_i       = '0;
    core_csr_valid_i = 1'b0;
    debug_halt_i     = 1'b0;
    halt_armed       = 1'b0;
    halt_wait        = '0;
    cycle_count      = 0;
    rng_state        = Seed;
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;
    for (int round = 0; round < NumRounds; round++) begin
      // Round 1 commits nothing so it replays the same state as round 0
      idle_cycles = (round == 1) ? 0 : CommitCycles;
      repeat (idle_cycles) begin
        @(negedge clk_i);
        drive_commits(1'b0);
      end
      @(negedge clk_i);
      drive_commits(1'b1);
      // Commits and stray start pulses keep coming during recovery
      finished_seen = 1'b0;
      while (!finished_seen) begin
        @(negedge clk_i);
        finished_seen = recovery_finished_o;
        start_draw    = rand_word();
        drive_commits(start_draw[1:0] == 2'b00);
        answer_debug();
      end
    end
    @(negedge clk_i);
    drive_commits(1'b0);
    repeat (2) @(negedge clk_i);
    $display("TEST PASSED");
    $finish;
  end

endmodule

// ==== sim.f ====
common/rapid_recovery_pkg.sv
logic/rf_backup.sv
logic/state_backup.sv
recovery/rf_addr_gen.sv
recovery/recovery_ctrl.sv
recovery/rapid_recovery_unit.sv
sim/tb_rapid_recovery.sv

// ==== Bender.yml ====
package:
  name: rapid_recovery

sources:
  # Shared package
  - common/rapid_recovery_pkg.sv
  # Shadow stores
  - logic/rf_backup.sv
  - logic/state_backup.sv
  # Sequencer, address walk and top level
  - recovery/rf_addr_gen.sv
  - recovery/recovery_ctrl.sv
  - recovery/rapid_recovery_unit.sv
  # Testbench
  - target: simulation
    files:
      - sim/tb_rapid_recovery.sv
